// ==== common/usbh_defs.svh ====
//--------------------------------------------------------------------------
// Shared constants for the USB full-speed host SIE
// Include in every file that needs the clock rate, the line timing limits
// or the field widths
//--------------------------------------------------------------------------
`ifndef USBH_DEFS_SVH
`define USBH_DEFS_SVH

// Core clock in Hz, 48 MHz or 60 MHz
`define USBH_CLK_FREQ 48000000

//--------------------------------------------------------------------------
// Field widths
//--------------------------------------------------------------------------
// Payload length
`define USBH_LEN_W 16
// Response timeout timer
`define USBH_TIMER_W 9
// Inter-packet gap counter
`define USBH_IFS_W 4

//--------------------------------------------------------------------------
// Line timing
//--------------------------------------------------------------------------
// Cycles after the last sent byte before a response counts as missing
`define USBH_RX_TIMEOUT ((`USBH_CLK_FREQ == 60000000) ? 9'd511 : 9'd255)

// Two FS bit times of gap, 4 or 5 clocks per bit
`define USBH_TX_IFS ((`USBH_CLK_FREQ == 60000000) ? 4'd10 : 4'd7)

`endif

// ==== common/usbh_pkg.sv ====
//--------------------------------------------------------------------------
// Types and CRC helpers shared by the USB host SIE
// Import by wildcard in the module header of any block that needs the
// transfer states, the PID codes or the CRC functions
//--------------------------------------------------------------------------
package usbh_pkg;

    // Transfer sequence states
    typedef enum logic [3:0] {
        IDLE,
        TX_TOKEN1,
        TX_TOKEN2,
        TX_TOKEN3,
        TX_IFS,
        TX_PID,
        TX_DATA,
        TX_CRC1,
        TX_CRC2,
        RX_WAIT,
        RX_PKT
    } usbh_state_t;

    // PID byte as sent on the wire, check nibble included
    typedef enum logic [7:0] {
        PID_OUT   = 8'hE1,
        PID_IN    = 8'h69,
        PID_SOF   = 8'hA5,
        PID_SETUP = 8'h2D,
        PID_DATA0 = 8'hC3,
        PID_DATA1 = 8'h4B,
        PID_ACK   = 8'hD2,
        PID_NAK   = 8'h5A,
        PID_STALL = 8'h1E
    } usbh_pid_t;

    //----------------------------------------------------------------------
    // CRC5 over the 11-bit address/endpoint field
    //----------------------------------------------------------------------
    // Field bit 0 goes first, x^5+x^2+1, seeded with ones, result inverted
    function automatic logic [4:0] usbh_crc5_step(input logic [10:0] field);
        logic [4:0] crc;
        logic       fb;
        crc = 5'h1F;
        for (int i = 0; i < 11; i++)
        begin
            fb  = crc[4] ^ field[i];
            crc = {crc[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
        end
        return ~crc;
    endfunction

    //----------------------------------------------------------------------
    // CRC16 advanced by one payload byte
    //----------------------------------------------------------------------
    // Reflected form of 0x8005, data LSB first
    function automatic logic [15:0] usbh_crc16_step(input logic [15:0] crc,
                                                    input logic [7:0]  data);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ 16'hA001;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

// ==== sie/usbh_sie_ctrl.sv ====
//--------------------------------------------------------------------------
// Transfer controller of the USB host SIE
// Steps through token, gap, data packet and handshake, one state per
// accepted byte; holds the request, the payload count and the status
//--------------------------------------------------------------------------
`include "usbh_defs.svh"

module usbh_sie_ctrl
    import usbh_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Host request
    input  logic                   start_i,
    input  logic                   resp_expected_i,
    input  logic [7:0]             token_pid_i,
    input  logic [`USBH_LEN_W-1:0] data_len_i,
    // PHY
    input  logic                   utmi_txready_i,
    input  logic                   utmi_rxvalid_i,
    input  logic                   utmi_rxactive_i,
    input  logic [7:0]             utmi_data_i,
    // Line timer
    input  logic                   ifs_busy_i,
    input  logic                   resp_timeout_i,
    // Transmit path and line timer control
    output usbh_state_t            state_o,
    output logic                   load_o,
    output logic                   tx_end_o,
    // Host status
    output logic                   ack_o,
    output logic                   tx_pop_o,
    output logic                   done_o,
    output logic                   timeout_o,
    output logic                   idle_o,
    output logic [7:0]             response_o
);

    usbh_state_t            state_q;
    usbh_state_t            state_d;
    logic [`USBH_LEN_W-1:0] byte_cnt_q;
    logic                   sof_q;
    logic                   resp_q;
    logic                   ack_q;
    logic                   done_q;
    logic                   timeout_q;
    logic [7:0]             response_q;
    logic                   rx_byte_w;

    // Request taken only while idle
    assign load_o    = (state_q == IDLE) && start_i;
    assign rx_byte_w = utmi_rxactive_i && utmi_rxvalid_i;

    //----------------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_i)
                    state_d = TX_TOKEN1;
            TX_TOKEN1:
                if (utmi_txready_i)
                    state_d = TX_TOKEN2;
            TX_TOKEN2:
                if (utmi_txready_i)
                    state_d = TX_TOKEN3;
            TX_TOKEN3:
                if (utmi_txready_i)
                    state_d = TX_IFS;
            // Wait out EOP and gap, SOF stops here
            TX_IFS:
                if (!ifs_busy_i)
                    state_d = sof_q ? IDLE : TX_PID;
            // Zero length packet goes straight to the CRC
            TX_PID:
                if (utmi_txready_i)
                    state_d = (data_len_i == '0) ? TX_CRC1 : TX_DATA;
            TX_DATA:
                if (utmi_txready_i && (byte_cnt_q == `USBH_LEN_W'd1))
                    state_d = TX_CRC1;
            TX_CRC1:
                if (utmi_txready_i)
                    state_d = TX_CRC2;
            TX_CRC2:
                if (utmi_txready_i)
                    state_d = resp_q ? RX_WAIT : IDLE;
            // First byte wins over the timeout
            RX_WAIT:
                if (rx_byte_w)
                    state_d = RX_PKT;
                else if (resp_timeout_i)
                    state_d = IDLE;
            RX_PKT:
                if (!utmi_rxactive_i)
                    state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    //----------------------------------------------------------------------
    // Request capture and payload count
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            sof_q      <= 1'b0;
            resp_q     <= 1'b0;
            byte_cnt_q <= '0;
        end
        else if (load_o)
        begin
            sof_q      <= (token_pid_i == PID_SOF);
            resp_q     <= resp_expected_i;
            byte_cnt_q <= data_len_i;
        end
        // One down per payload byte taken by the PHY
        else if ((state_q == TX_DATA) && utmi_txready_i)
            byte_cnt_q <= byte_cnt_q - `USBH_LEN_W'd1;
    end

    //----------------------------------------------------------------------
    // Status
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            ack_q      <= 1'b0;
            done_q     <= 1'b0;
            timeout_q  <= 1'b0;
            response_q <= 8'h00;
        end
        else
        begin
            // Ack once the token PID has gone out
            ack_q  <= (state_q == TX_TOKEN1) && utmi_txready_i;
            done_q <= (state_q != IDLE) && (state_d == IDLE);
            // Previous result held until the next request
            if (load_o)
            begin
                timeout_q  <= 1'b0;
                response_q <= 8'h00;
            end
            else if (state_q == RX_WAIT)
            begin
                if (rx_byte_w)
                    response_q <= utmi_data_i;
                else if (resp_timeout_i)
                    timeout_q <= 1'b1;
            end
        end
    end

    // Last byte of token or data packet accepted
    assign tx_end_o   = ((state_q == TX_TOKEN3) || (state_q == TX_CRC2)) && utmi_txready_i;
    assign tx_pop_o   = (state_q == TX_DATA) && utmi_txready_i;
    assign state_o    = state_q;
    assign ack_o      = ack_q;
    assign done_o     = done_q;
    assign timeout_o  = timeout_q;
    assign response_o = response_q;
    assign idle_o     = (state_q == IDLE);

endmodule

// ==== sie/usbh_tx_path.sv ====
//--------------------------------------------------------------------------
// Transmit byte path of the USB host SIE
// Holds the token with its CRC5, runs the CRC16 over the payload and
// picks the byte for the PHY from the controller state
//--------------------------------------------------------------------------
`include "usbh_defs.svh"

module usbh_tx_path
    import usbh_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    // Controller
    input  usbh_state_t state_i,
    input  logic        load_i,
    // Host request and payload
    input  logic [7:0]  token_pid_i,
    input  logic [6:0]  token_dev_i,
    input  logic [3:0]  token_ep_i,
    input  logic        data_idx_i,
    input  logic [7:0]  tx_data_i,
    // PHY
    input  logic        utmi_txready_i,
    output logic        utmi_txvalid_o,
    output logic [7:0]  utmi_data_o
);

    logic [7:0]  pid_q;
    logic [15:0] token_q;
    logic        data1_q;
    logic [15:0] crc_q;
    logic [4:0]  crc5_w;

    // Address in the low bits, sent first
    assign crc5_w = usbh_crc5_step({token_ep_i, token_dev_i});

    //----------------------------------------------------------------------
    // Token capture
    //----------------------------------------------------------------------
    // Wire order, fields LSB first and CRC5 MSB first
    always_ff @(posedge clk_i)
    begin
        if (load_i)
        begin
            pid_q   <= token_pid_i;
            token_q <= {crc5_w[0], crc5_w[1], crc5_w[2], crc5_w[3], crc5_w[4],
                        token_ep_i, token_dev_i};
            data1_q <= data_idx_i;
        end
    end

    //----------------------------------------------------------------------
    // CRC16 over the payload
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            crc_q <= 16'hFFFF;
        // Data PID is not covered, restart here
        else if (state_i == TX_PID)
            crc_q <= 16'hFFFF;
        else if ((state_i == TX_DATA) && utmi_txready_i)
            crc_q <= usbh_crc16_step(crc_q, tx_data_i);
    end

    //----------------------------------------------------------------------
    // Byte select
    //----------------------------------------------------------------------
    always_comb
    begin
        utmi_txvalid_o = 1'b1;
        utmi_data_o    = 8'h00;
        case (state_i)
            TX_TOKEN1: utmi_data_o = pid_q;
            TX_TOKEN2: utmi_data_o = token_q[7:0];
            TX_TOKEN3: utmi_data_o = token_q[15:8];
            TX_PID:    utmi_data_o = data1_q ? PID_DATA1 : PID_DATA0;
            TX_DATA:   utmi_data_o = tx_data_i;
            // Inverted sum, low byte first
            TX_CRC1:   utmi_data_o = ~crc_q[7:0];
            TX_CRC2:   utmi_data_o = ~crc_q[15:8];
            default:   utmi_txvalid_o = 1'b0;
        endcase
    end

endmodule

// ==== sie/usbh_line_timer.sv ====
//--------------------------------------------------------------------------
// Line timing for the USB host SIE
// Finds end of packet from the line state, holds the inter-packet gap and
// times the wait for a device response after the last sent byte
//--------------------------------------------------------------------------
`include "usbh_defs.svh"

module usbh_line_timer
    import usbh_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // Last byte of a token or data packet taken
    input  logic       tx_end_i,
    // PHY
    input  logic       utmi_txvalid_i,
    input  logic       utmi_txready_i,
    input  logic       utmi_rxactive_i,
    input  logic [1:0] utmi_linestate_i,
    // Controller
    output logic       ifs_busy_o,
    output logic       resp_timeout_o
);

    logic [1:0]               linestate_q;
    logic                     se0_q;
    logic                     se0_w;
    logic                     eop_w;
    logic                     rxactive_q;
    logic                     wait_eop_q;
    logic [`USBH_IFS_W-1:0]   ifs_cnt_q;
    logic [`USBH_TIMER_W-1:0] idle_cnt_q;

    // SE0 on two samples in a row, first such cycle only
    assign se0_w = (linestate_q == 2'b00) && (utmi_linestate_i == 2'b00);
    assign eop_w = se0_w && !se0_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            linestate_q <= 2'b01;
            se0_q       <= 1'b0;
            rxactive_q  <= 1'b0;
        end
        else
        begin
            linestate_q <= utmi_linestate_i;
            se0_q       <= se0_w;
            rxactive_q  <= utmi_rxactive_i;
        end
    end

    //----------------------------------------------------------------------
    // Gap after each packet
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            wait_eop_q <= 1'b0;
        else if (eop_w)
            wait_eop_q <= 1'b0;
        // Own transmit done or device started sending
        else if (tx_end_i || (utmi_rxactive_i && !rxactive_q))
            wait_eop_q <= 1'b1;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            ifs_cnt_q <= '0;
        else if (wait_eop_q || eop_w)
            ifs_cnt_q <= `USBH_TX_IFS;
        else if (ifs_cnt_q != '0)
            ifs_cnt_q <= ifs_cnt_q - `USBH_IFS_W'd1;
    end

    assign ifs_busy_o = wait_eop_q || (ifs_cnt_q != '0);

    //----------------------------------------------------------------------
    // Response timeout
    //----------------------------------------------------------------------
    // Restarts on every byte the PHY takes, stops at the limit
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            idle_cnt_q <= '0;
        else if (utmi_txvalid_i && utmi_txready_i)
            idle_cnt_q <= '0;
        else if (idle_cnt_q != `USBH_RX_TIMEOUT)
            idle_cnt_q <= idle_cnt_q + `USBH_TIMER_W'd1;
    end

    assign resp_timeout_o = (idle_cnt_q == `USBH_RX_TIMEOUT);

endmodule

// ==== source/usbh_sie_top.sv ====
//--------------------------------------------------------------------------
// Top level of the USB full-speed host SIE
// Host side issues SOF, OUT and SETUP transfers and reads back the
// handshake; PHY side is a UTMI-style byte interface
//--------------------------------------------------------------------------
`include "usbh_defs.svh"

module usbh_sie_top
    import usbh_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Host request
    input  logic                   start_i,
    input  logic                   resp_expected_i,
    input  logic                   data_idx_i,
    input  logic [7:0]             token_pid_i,
    input  logic [6:0]             token_dev_i,
    input  logic [3:0]             token_ep_i,
    input  logic [`USBH_LEN_W-1:0] data_len_i,
    input  logic [7:0]             tx_data_i,
    // UTMI receive and line state
    input  logic                   utmi_txready_i,
    input  logic                   utmi_rxvalid_i,
    input  logic                   utmi_rxactive_i,
    input  logic [7:0]             utmi_data_i,
    input  logic [1:0]             utmi_linestate_i,
    // Host status
    output logic                   ack_o,
    output logic                   tx_pop_o,
    output logic                   done_o,
    output logic                   timeout_o,
    output logic                   idle_o,
    output logic [7:0]             response_o,
    // UTMI transmit
    output logic                   utmi_txvalid_o,
    output logic [7:0]             utmi_data_o
);

    usbh_state_t state_w;
    logic        load_w;
    logic        tx_end_w;
    logic        ifs_busy_w;
    logic        resp_timeout_w;

    // Transfer sequencing and status
    usbh_sie_ctrl i_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .resp_expected_i (resp_expected_i),
        .token_pid_i     (token_pid_i),
        .data_len_i      (data_len_i),
        .utmi_txready_i  (utmi_txready_i),
        .utmi_rxvalid_i  (utmi_rxvalid_i),
        .utmi_rxactive_i (utmi_rxactive_i),
        .utmi_data_i     (utmi_data_i),
        .ifs_busy_i      (ifs_busy_w),
        .resp_timeout_i  (resp_timeout_w),
        .state_o         (state_w),
        .load_o          (load_w),
        .tx_end_o        (tx_end_w),
        .ack_o           (ack_o),
        .tx_pop_o        (tx_pop_o),
        .done_o          (done_o),
        .timeout_o       (timeout_o),
        .idle_o          (idle_o),
        .response_o      (response_o)
    );

    // Byte source toward the PHY
    usbh_tx_path i_tx_path (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .state_i        (state_w),
        .load_i         (load_w),
        .token_pid_i    (token_pid_i),
        .token_dev_i    (token_dev_i),
        .token_ep_i     (token_ep_i),
        .data_idx_i     (data_idx_i),
        .tx_data_i      (tx_data_i),
        .utmi_txready_i (utmi_txready_i),
        .utmi_txvalid_o (utmi_txvalid_o),
        .utmi_data_o    (utmi_data_o)
    );

    // EOP, gap and response timing
    usbh_line_timer i_line_timer (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .tx_end_i         (tx_end_w),
        .utmi_txvalid_i   (utmi_txvalid_o),
        .utmi_txready_i   (utmi_txready_i),
        .utmi_rxactive_i  (utmi_rxactive_i),
        .utmi_linestate_i (utmi_linestate_i),
        .ifs_busy_o       (ifs_busy_w),
        .resp_timeout_o   (resp_timeout_w)
    );

endmodule

// ==== test/tb_usbh_sie.sv ====
//--------------------------------------------------------------------------
// Self-checking testbench for the USB full-speed host SIE
// Reads one transfer per line from the data file, plays host, PHY and
// device around the DUT and checks every byte, strobe and status result
//--------------------------------------------------------------------------
`include "usbh_defs.svh"

module tb_usbh_sie
    import usbh_pkg::*;
();

    logic                   clk_i;
    logic                   rst_i;
    logic                   start_i;
    logic                   resp_expected_i;
    logic                   data_idx_i;
    logic [7:0]             token_pid_i;
    logic [6:0]             token_dev_i;
    logic [3:0]             token_ep_i;
    logic [`USBH_LEN_W-1:0] data_len_i;
    logic [7:0]             tx_data_i;
    logic                   utmi_txready_i;
    logic                   utmi_rxvalid_i;
    logic                   utmi_rxactive_i;
    logic [7:0]             utmi_data_i;
    logic [1:0]             utmi_linestate_i;
    logic                   ack_o;
    logic                   tx_pop_o;
    logic                   done_o;
    logic                   timeout_o;
    logic                   idle_o;
    logic [7:0]             response_o;
    logic                   utmi_txvalid_o;
    logic [7:0]             utmi_data_o;

    // Transfer table, 15 hex fields per line
    logic [7:0] rec [0:31][0:14];
    int         num_lines;
    int         limit_cycles;
    integer     seed;

    usbh_sie_top i_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start_i          (start_i),
        .resp_expected_i  (resp_expected_i),
        .data_idx_i       (data_idx_i),
        .token_pid_i      (token_pid_i),
        .token_dev_i      (token_dev_i),
        .token_ep_i       (token_ep_i),
        .data_len_i       (data_len_i),
        .tx_data_i        (tx_data_i),
        .utmi_txready_i   (utmi_txready_i),
        .utmi_rxvalid_i   (utmi_rxvalid_i),
        .utmi_rxactive_i  (utmi_rxactive_i),
        .utmi_data_i      (utmi_data_i),
        .utmi_linestate_i (utmi_linestate_i),
        .ack_o            (ack_o),
        .tx_pop_o         (tx_pop_o),
        .done_o           (done_o),
        .timeout_o        (timeout_o),
        .idle_o           (idle_o),
        .response_o       (response_o),
        .utmi_txvalid_o   (utmi_txvalid_o),
        .utmi_data_o      (utmi_data_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //----------------------------------------------------------------------
    // Compare and stop on the first mismatch
    //----------------------------------------------------------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("** Error at time %0t: %s, got %0h, expected %0h",
                     $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    //----------------------------------------------------------------------
    // Load the transfer table
    //----------------------------------------------------------------------
    task automatic read_table();
        int    fd;
        int    cnt;
        int    f [0:14];
        string line;
        fd = $fopen("test/usbh_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the transfer table test/usbh_testdata.txt");
            $display("*** FAILED ***");
            $fatal(1, "Missing data file");
        end
        num_lines = 0;
        while (!$feof(fd) && num_lines < 32)
        begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines give no fields
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                          f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (cnt == 15)
            begin
                for (int k = 0; k < 15; k++)
                    rec[num_lines][k] = f[k][7:0];
                num_lines++;
            end
        end
        $fclose(fd);
    endtask

    //----------------------------------------------------------------------
    // One transfer with host, PHY and device models
    //----------------------------------------------------------------------
    task automatic run_transfer(input int n);
        logic [7:0] got [$];
        logic [7:0] rsp;
        int         len;
        int         acks;
        int         pops;
        int         pay_idx;
        int         pkt_bytes;
        int         pkt_no;
        int         se0_left;
        int         rx_timer;
        int         cyc;
        int         last_cyc;
        int         done_cyc;
        bit         start_q;
        bit         rx_on;
        bit         done_seen;
        bit         is_sof;
        len       = rec[n][3];
        rsp       = rec[n][10];
        is_sof    = (rec[n][0] == PID_SOF);
        acks      = 0;
        pops      = 0;
        pay_idx   = 0;
        pkt_bytes = 0;
        pkt_no    = 0;
        se0_left  = 0;
        rx_timer  = 0;
        cyc       = 0;
        last_cyc  = 0;
        done_cyc  = 0;
        start_q   = 1'b1;
        rx_on     = 1'b0;
        done_seen = 1'b0;
        while (!done_seen)
        begin
            @(posedge clk_i);
            #1;
            // Host request held, start dropped after ack
            start_i         = start_q;
            token_pid_i     = rec[n][0];
            token_dev_i     = rec[n][1][6:0];
            token_ep_i      = rec[n][2][3:0];
            data_len_i      = len;
            data_idx_i      = rec[n][4][0];
            resp_expected_i = rec[n][5][0];
            tx_data_i       = (pay_idx < 4) ? rec[n][6 + pay_idx] : 8'h00;
            utmi_txready_i  = (($random(seed) & 3) != 0);
            // Device handshake 20 cycles after the data packet
            if (rx_on)
            begin
                rx_timer++;
                if (rx_timer == 20)
                    utmi_rxactive_i = 1'b1;
                else if (rx_timer == 21)
                begin
                    utmi_rxvalid_i = 1'b1;
                    utmi_data_i    = rsp;
                end
                else if (rx_timer == 22)
                begin
                    utmi_rxactive_i = 1'b0;
                    utmi_rxvalid_i  = 1'b0;
                    se0_left        = 2;
                    rx_on           = 1'b0;
                end
            end
            if (se0_left > 0)
            begin
                utmi_linestate_i = 2'b00;
                se0_left--;
            end
            else
                utmi_linestate_i = 2'b01;
            @(negedge clk_i);
            cyc++;
            if (done_o)
                check_value(idle_o, 1, "idle_o at done_o");
            else if (cyc > 1)
                check_value(idle_o, 0, "idle_o during transfer");
            if (ack_o)
            begin
                acks++;
                start_q = 1'b0;
            end
            if (tx_pop_o)
            begin
                pops++;
                pay_idx++;
            end
            // Byte taken by the PHY this cycle
            if (utmi_txvalid_o && utmi_txready_i)
            begin
                // Data packet only after two SE0 samples and the full gap
                if (pkt_no == 1 && pkt_bytes == 0)
                    check_value(cyc - last_cyc >= 2 + `USBH_TX_IFS, 1,
                                "data packet inside the gap");
                got.push_back(utmi_data_o);
                last_cyc = cyc;
                pkt_bytes++;
                if (pkt_bytes == ((pkt_no == 0) ? 3 : len + 3))
                begin
                    pkt_bytes = 0;
                    se0_left  = 2;
                    pkt_no++;
                    if (pkt_no == 2 && rec[n][5][0] && rsp != 8'h00)
                    begin
                        rx_on    = 1'b1;
                        rx_timer = 0;
                    end
                end
            end
            if (done_o)
            begin
                done_seen = 1'b1;
                done_cyc  = cyc;
            end
        end

        check_value(acks, 1, "ack_o pulses");
        check_value(got.size(), is_sof ? 3 : len + 6, "bytes sent");
        check_value(got[0], rec[n][0], "token PID");
        check_value(got[1], rec[n][11], "token byte 2");
        check_value(got[2], rec[n][12], "token byte 3");
        if (is_sof)
        begin
            check_value(pops, 0, "tx_pop_o count for SOF");
            check_value(timeout_o, 0, "timeout_o after SOF");
            check_value(response_o, 0, "response_o after SOF");
        end
        else
        begin
            check_value(got[3], rec[n][4][0] ? PID_DATA1 : PID_DATA0, "data PID");
            for (int k = 0; k < len; k++)
                check_value(got[4 + k], rec[n][6 + k], "payload byte");
            check_value(pops, len, "tx_pop_o count");
            check_value(got[4 + len], rec[n][13], "CRC16 low byte");
            check_value(got[5 + len], rec[n][14], "CRC16 high byte");
            if (rec[n][5][0] && rsp != 8'h00)
            begin
                check_value(response_o, rsp, "captured handshake");
                check_value(timeout_o, 0, "timeout_o with handshake");
            end
            else if (rec[n][5][0])
            begin
                check_value(timeout_o, 1, "timeout_o on silence");
                check_value(response_o, 0, "response_o on silence");
                check_value(done_cyc - last_cyc >= `USBH_RX_TIMEOUT, 1,
                            "timeout came too early");
            end
            else
            begin
                check_value(timeout_o, 0, "timeout_o without response");
                check_value(response_o, 0, "response_o without response");
            end
        end

        // Quiet cycles, finish any pending EOP
        repeat (4)
        begin
            @(posedge clk_i);
            #1;
            start_i        = 1'b0;
            utmi_txready_i = (($random(seed) & 3) != 0);
            if (se0_left > 0)
            begin
                utmi_linestate_i = 2'b00;
                se0_left--;
            end
            else
                utmi_linestate_i = 2'b01;
            @(negedge clk_i);
            check_value(done_o, 0, "done_o longer than one cycle");
            check_value(idle_o, 1, "idle_o between transfers");
            check_value(utmi_txvalid_o, 0, "utmi_txvalid_o between transfers");
        end
    endtask

    //----------------------------------------------------------------------
    // Watchdog sized from the number of transfers
    //----------------------------------------------------------------------
    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Watchdog expired because a transfer never signalled done_o");
        $display("*** FAILED ***");
        $fatal(1, "Simulation timeout");
    end

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial
    begin
        seed             = 21;
        rst_i            = 1'b1;
        start_i          = 1'b0;
        resp_expected_i  = 1'b0;
        data_idx_i       = 1'b0;
        token_pid_i      = 8'h00;
        token_dev_i      = 7'h00;
        token_ep_i       = 4'h0;
        data_len_i       = '0;
        tx_data_i        = 8'h00;
        utmi_txready_i   = 1'b0;
        utmi_rxvalid_i   = 1'b0;
        utmi_rxactive_i  = 1'b0;
        utmi_data_i      = 8'h00;
        utmi_linestate_i = 2'b01;
        read_table();
        if (num_lines == 0)
        begin
            $display("The transfer table holds no transfers");
            $display("*** FAILED ***");
            $fatal(1, "Empty data file");
        end
        limit_cycles = num_lines * (80 + `USBH_RX_TIMEOUT) + 32;

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        // Values still under reset
        check_value(ack_o, 0, "ack_o in reset");
        check_value(tx_pop_o, 0, "tx_pop_o in reset");
        check_value(done_o, 0, "done_o in reset");
        check_value(timeout_o, 0, "timeout_o in reset");
        check_value(utmi_txvalid_o, 0, "utmi_txvalid_o in reset");
        check_value(response_o, 0, "response_o in reset");
        check_value(idle_o, 1, "idle_o in reset");
        @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        for (int n = 0; n < num_lines; n++)
            run_transfer(n);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== test/usbh_testdata.txt ====
# pid dev ep len idx resp | p0 p1 p2 p3 | rsp | tok2 tok3 | crc_lo crc_hi
# All fields hex, rsp 00 means the device stays silent
A5 01 0 0 0 0 00 00 00 00 00 01 E8 00 00
2D 00 0 4 0 1 00 01 02 03 D2 00 10 EF 7A
E1 01 0 0 1 1 00 00 00 00 D2 01 E8 00 00
E1 00 1 1 0 1 00 00 00 00 5A 80 A0 40 BF
E1 01 1 2 1 1 00 01 00 00 1E 81 58 3F 8F
E1 00 0 3 0 1 00 01 02 00 00 00 10 0E 6E
E1 01 0 4 1 0 00 01 02 03 00 01 E8 EF 7A
A5 00 1 0 0 0 00 00 00 00 00 80 A0 00 00
2D 01 1 4 0 1 00 01 02 03 D2 81 58 EF 7A
E1 00 0 0 0 0 00 00 00 00 00 00 10 00 00
E1 00 1 2 0 1 00 01 00 00 D2 80 A0 3F 8F
2D 00 0 1 1 0 00 00 00 00 00 00 10 40 BF

// ==== sim.f ====
+incdir+common
common/usbh_pkg.sv
sie/usbh_sie_ctrl.sv
sie/usbh_tx_path.sv
sie/usbh_line_timer.sv
source/usbh_sie_top.sv
test/tb_usbh_sie.sv

// ==== Makefile ====
# Verilator build for the USB host SIE testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_usbh_sie
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
